/* common/cache_pkg.sv */
package cache_pkg;

    // Cache geometry
    localparam int INDEX_W  = 8;
    localparam int TAG_W    = 20;
    localparam int OFFSET_W = 4;
    localparam int WAYS     = 2;
    localparam int BANKS    = 4;
    localparam int LINE_W   = 128;

    // Main memory model
    localparam int MEM_LINE_BITS = 12;
    localparam int MEM_LATENCY   = 2;

    typedef enum logic {
        OP_LOAD,
        OP_STORE
    } cache_op_e;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS,
        ST_REPLACE,
        ST_REFILL
    } cache_state_e;

    typedef enum logic {
        WRBUF_IDLE,
        WRBUF_WRITE
    } wrbuf_state_e;

    typedef struct packed {
        cache_op_e           op;
        logic [INDEX_W-1:0]  index;
        logic [TAG_W-1:0]    tag;
        logic [OFFSET_W-1:0] offset;
        logic [3:0]          wstrb;
        logic [31:0]         wdata;
    } cache_req_t;

    // Line read uses rd_type 3'b100
    typedef struct packed {
        logic [2:0]  rd_type;
        logic [31:0] rd_addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic [2:0]        wr_type;
        logic [31:0]       wr_addr;
        logic [3:0]        wr_wstrb;
        logic [LINE_W-1:0] wr_data;
    } mem_wr_req_t;

    typedef struct packed {
        logic        ret_last;
        logic [31:0] ret_data;
    } mem_ret_t;

endpackage

/* cache/cache_ram.sv */
`timescale 1ns/1ps

module cache_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 256
) (
    input  logic                                           clk_g,
    input  logic                                           we,
    input  logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] addr,
    input  logic [WIDTH-1:0]                               wdata,
    output logic [WIDTH-1:0]                               rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Read returns the contents before a same-cycle write
    always_ff @(posedge clk_g) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* cache/cache.sv */
`timescale 1ns/1ps

module cache (
    input  logic                   clk_g,
    input  logic                   rst,
    input  cache_pkg::cache_req_t  req,
    input  logic                   req_valid,
    output logic                   addr_ok,
    output logic                   data_ok,
    output logic [31:0]            rdata,
    output cache_pkg::mem_rd_req_t rd_req,
    output logic                   rd_valid,
    input  logic                   rd_rdy,
    input  cache_pkg::mem_ret_t    ret,
    input  logic                   ret_valid,
    output cache_pkg::mem_wr_req_t wr_req,
    output logic                   wr_valid,
    input  logic                   wr_rdy
);
    import cache_pkg::*;

    cache_state_e state;
    cache_state_e state_nxt;
    wrbuf_state_e wb_state;
    cache_req_t   req_r;

    logic [INDEX_W-1:0]        init_cnt;
    logic [7:0]                lfsr;
    logic                      victim;
    logic [1:0]                beat_cnt;
    logic                      miss_done;
    logic [31:0]               miss_word;
    logic [(1 << INDEX_W)-1:0] dirty [WAYS];

    // One-entry write buffer
    logic               wb_way;
    logic [INDEX_W-1:0] wb_index;
    logic [1:0]         wb_bank;
    logic [31:0]        wb_data;

    logic               tag_we [WAYS];
    logic [INDEX_W-1:0] tag_addr;
    logic [TAG_W:0]     tag_wdata;
    logic [TAG_W:0]     tag_rdata [WAYS];

    logic               bank_we [WAYS][BANKS];
    logic [INDEX_W-1:0] bank_addr [BANKS];
    logic [31:0]        bank_wdata;
    logic [31:0]        bank_rdata [WAYS][BANKS];

    logic [WAYS-1:0]   way_hit;
    logic              hit;
    logic              hit_way;
    logic [31:0]       hit_word;
    logic [1:0]        req_bank;
    logic              store_hit;
    logic              refill_last;
    logic              victim_dirty;
    logic [TAG_W-1:0]  victim_tag;
    logic [LINE_W-1:0] victim_line;
    logic [31:0]       refill_word;

    function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

    // Tag compare, tag RAM bit TAG_W is the valid bit
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = tag_rdata[w][TAG_W] && (tag_rdata[w][TAG_W-1:0] == req_r.tag);
        end
    end

    assign hit          = |way_hit;
    assign hit_way      = way_hit[1];
    assign req_bank     = req_r.offset[OFFSET_W-1:2];
    assign hit_word     = bank_rdata[hit_way][req_bank];
    assign store_hit    = (state == ST_LOOKUP) && hit && (req_r.op == OP_STORE);
    assign refill_last  = (state == ST_REFILL) && ret_valid && ret.ret_last;
    assign victim_tag   = tag_rdata[victim][TAG_W-1:0];
    assign victim_dirty = tag_rdata[victim][TAG_W] && dirty[victim][req_r.index];
    assign victim_line  = {bank_rdata[victim][3], bank_rdata[victim][2],
                           bank_rdata[victim][1], bank_rdata[victim][0]};
    assign refill_word  = (req_r.op == OP_STORE && beat_cnt == req_bank) ?
                          merge_word(ret.ret_data, req_r.wdata, req_r.wstrb) : ret.ret_data;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_INIT:    if (init_cnt == '1) state_nxt = ST_IDLE;
            ST_IDLE:    if (req_valid && addr_ok) state_nxt = ST_LOOKUP;
            ST_LOOKUP:  state_nxt = hit ? ST_IDLE : ST_MISS;
            ST_MISS:    if (!victim_dirty || wr_rdy) state_nxt = ST_REPLACE;
            ST_REPLACE: if (rd_rdy) state_nxt = ST_REFILL;
            ST_REFILL:  if (refill_last) state_nxt = ST_IDLE;
            default:    state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_g) begin
        if (rst) begin
            state     <= ST_INIT;
            wb_state  <= WRBUF_IDLE;
            init_cnt  <= '0;
            lfsr      <= 8'h01;
            beat_cnt  <= '0;
            miss_done <= 1'b0;
        end else begin
            state     <= state_nxt;
            wb_state  <= store_hit ? WRBUF_WRITE : WRBUF_IDLE;
            lfsr      <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            miss_done <= refill_last;
            if (state == ST_INIT) begin
                init_cnt <= init_cnt + 1'b1;
            end
            if (state == ST_REPLACE) begin
                beat_cnt <= '0;
            end else if (state == ST_REFILL && ret_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_g) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                dirty[w] <= '0;
            end
        end else if (store_hit) begin
            dirty[hit_way][req_r.index] <= 1'b1;
        end else if (refill_last) begin
            dirty[victim][req_r.index] <= (req_r.op == OP_STORE);
        end
    end

    always_ff @(posedge clk_g) begin
        if (state == ST_IDLE && req_valid && addr_ok) begin
            req_r <= req;
        end
        if (state == ST_LOOKUP) begin
            victim <= lfsr[0];
        end
        if (store_hit) begin
            wb_way   <= hit_way;
            wb_index <= req_r.index;
            wb_bank  <= req_bank;
            wb_data  <= merge_word(hit_word, req_r.wdata, req_r.wstrb);
        end
        if (state == ST_REFILL && ret_valid && beat_cnt == req_bank) begin
            miss_word <= refill_word;
        end
    end

    // Sweep writes zero tags, refill writes the new tag with valid set
    assign tag_addr  = (state == ST_INIT) ? init_cnt :
                       (state == ST_IDLE) ? req.index : req_r.index;
    assign tag_wdata = (state == ST_INIT) ? '0 : {1'b1, req_r.tag};

    // Refill beats and the write buffer never share a cycle
    assign bank_wdata = (state == ST_REFILL) ? refill_word : wb_data;

    for (genvar b = 0; b < BANKS; b++) begin : g_bank_addr
        assign bank_addr[b] = (wb_state == WRBUF_WRITE && wb_bank == 2'(b)) ? wb_index :
                              (state == ST_IDLE) ? req.index : req_r.index;
    end

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        assign tag_we[w] = (state == ST_INIT) || (refill_last && victim == 1'(w));

        cache_ram #(.WIDTH(TAG_W + 1), .DEPTH(1 << INDEX_W)) tag_ram (
            .clk_g (clk_g),
            .we    (tag_we[w]),
            .addr  (tag_addr),
            .wdata (tag_wdata),
            .rdata (tag_rdata[w])
        );

        for (genvar b = 0; b < BANKS; b++) begin : g_bank
            assign bank_we[w][b] =
                (state == ST_REFILL && ret_valid && victim == 1'(w) && beat_cnt == 2'(b)) ||
                (wb_state == WRBUF_WRITE && wb_way == 1'(w) && wb_bank == 2'(b));

            cache_ram #(.WIDTH(32), .DEPTH(1 << INDEX_W)) data_ram (
                .clk_g (clk_g),
                .we    (bank_we[w][b]),
                .addr  (bank_addr[b]),
                .wdata (bank_wdata),
                .rdata (bank_rdata[w][b])
            );
        end
    end

    // Hold off a request whose bank the write buffer is writing
    assign addr_ok = (state == ST_IDLE) &&
                     !(wb_state == WRBUF_WRITE && wb_bank == req.offset[OFFSET_W-1:2]);
    assign data_ok = ((state == ST_LOOKUP) && hit) || miss_done;
    assign rdata   = miss_done ? miss_word : hit_word;

    assign rd_valid        = (state == ST_REPLACE);
    assign rd_req.rd_type  = 3'b100;
    assign rd_req.rd_addr  = {req_r.tag, req_r.index, {OFFSET_W{1'b0}}};

    assign wr_valid        = (state == ST_MISS) && victim_dirty;
    assign wr_req.wr_type  = 3'b100;
    assign wr_req.wr_addr  = {victim_tag, req_r.index, {OFFSET_W{1'b0}}};
    assign wr_req.wr_wstrb = 4'hf;
    assign wr_req.wr_data  = victim_line;

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                   clk_g,
    input  logic                   rst,

    input  cache_pkg::mem_rd_req_t rd_req0,
    input  logic                   rd_valid0,
    output logic                   rd_rdy0,
    output cache_pkg::mem_ret_t    ret0,
    output logic                   ret_valid0,
    input  cache_pkg::mem_wr_req_t wr_req0,
    input  logic                   wr_valid0,
    output logic                   wr_rdy0,

    input  cache_pkg::mem_rd_req_t rd_req1,
    input  logic                   rd_valid1,
    output logic                   rd_rdy1,
    output cache_pkg::mem_ret_t    ret1,
    output logic                   ret_valid1,
    input  cache_pkg::mem_wr_req_t wr_req1,
    input  logic                   wr_valid1,
    output logic                   wr_rdy1,

    output cache_pkg::mem_rd_req_t m_rd_req,
    output logic                   m_rd_valid,
    input  logic                   m_rd_rdy,
    input  cache_pkg::mem_ret_t    m_ret,
    input  logic                   m_ret_valid,
    output cache_pkg::mem_wr_req_t m_wr_req,
    output logic                   m_wr_valid,
    input  logic                   m_wr_rdy
);

    logic busy;
    logic owner;
    logic rr_ptr;
    logic req0;
    logic req1;
    logic pick;
    logic sel;
    logic start_rd;
    logic start_wr;

    assign req0 = rd_valid0 | wr_valid0;
    assign req1 = rd_valid1 | wr_valid1;

    // Round-robin only matters when both ports ask
    assign pick = (req0 && req1) ? rr_ptr : req1;
    assign sel  = busy ? owner : pick;

    assign m_rd_req   = sel ? rd_req1 : rd_req0;
    assign m_wr_req   = sel ? wr_req1 : wr_req0;
    assign m_rd_valid = !busy && (sel ? rd_valid1 : rd_valid0);
    assign m_wr_valid = !busy && (sel ? wr_valid1 : wr_valid0);

    assign rd_rdy0 = !busy && !sel && m_rd_rdy;
    assign rd_rdy1 = !busy && sel && m_rd_rdy;
    assign wr_rdy0 = !busy && !sel && m_wr_rdy;
    assign wr_rdy1 = !busy && sel && m_wr_rdy;

    // Beats go to the read owner only
    assign ret0       = m_ret;
    assign ret1       = m_ret;
    assign ret_valid0 = busy && !owner && m_ret_valid;
    assign ret_valid1 = busy && owner && m_ret_valid;

    assign start_rd = m_rd_valid && m_rd_rdy;
    assign start_wr = m_wr_valid && m_wr_rdy;

    always_ff @(posedge clk_g) begin
        if (rst) begin
            busy   <= 1'b0;
            owner  <= 1'b0;
            rr_ptr <= 1'b0;
        end else begin
            if (start_rd) begin
                busy  <= 1'b1;
                owner <= sel;
            end else if (busy && m_ret_valid && m_ret.ret_last) begin
                busy <= 1'b0;
            end
            if (start_rd || start_wr) begin
                rr_ptr <= ~sel;
            end
        end
    end

endmodule

/* design/mem_model.sv */
`timescale 1ns/1ps

module mem_model (
    input  logic                   clk_g,
    input  logic                   rst,
    input  cache_pkg::mem_rd_req_t rd_req,
    input  logic                   rd_valid,
    output logic                   rd_rdy,
    output cache_pkg::mem_ret_t    ret,
    output logic                   ret_valid,
    input  cache_pkg::mem_wr_req_t wr_req,
    input  logic                   wr_valid,
    output logic                   wr_rdy
);
    import cache_pkg::*;

    logic [LINE_W-1:0]        mem [1 << MEM_LINE_BITS];
    logic                     busy;
    logic [7:0]               lat_cnt;
    logic [1:0]               beat_cnt;
    logic [MEM_LINE_BITS-1:0] rd_line;
    logic [LINE_W-1:0]        rd_data;

    assign rd_rdy = !busy;
    assign wr_rdy = !busy;

    assign rd_data       = mem[rd_line];
    assign ret_valid     = busy && (lat_cnt == '0);
    assign ret.ret_last  = (beat_cnt == 2'd3);
    assign ret.ret_data  = rd_data[32*beat_cnt +: 32];

    // Latency countdown, then four beats in bank order
    always_ff @(posedge clk_g) begin
        if (rst) begin
            busy     <= 1'b0;
            lat_cnt  <= '0;
            beat_cnt <= '0;
        end else if (!busy) begin
            if (rd_valid) begin
                busy     <= 1'b1;
                lat_cnt  <= 8'(MEM_LATENCY - 1);
                beat_cnt <= '0;
            end
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
        end else begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == 2'd3) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_g) begin
        if (rd_valid && rd_rdy) begin
            rd_line <= rd_req.rd_addr[OFFSET_W +: MEM_LINE_BITS];
        end
        // Whole line written
        if (wr_valid && wr_rdy) begin
            mem[wr_req.wr_addr[OFFSET_W +: MEM_LINE_BITS]] <= wr_req.wr_data;
        end
    end

endmodule

/* design/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
    input  logic                  clk_g,
    input  logic                  rst,

    input  cache_pkg::cache_req_t req0,
    input  logic                  req_valid0,
    output logic                  addr_ok0,
    output logic                  data_ok0,
    output logic [31:0]           rdata0,

    input  cache_pkg::cache_req_t req1,
    input  logic                  req_valid1,
    output logic                  addr_ok1,
    output logic                  data_ok1,
    output logic [31:0]           rdata1
);
    import cache_pkg::*;

    mem_rd_req_t rd_req0, rd_req1, m_rd_req;
    mem_wr_req_t wr_req0, wr_req1, m_wr_req;
    mem_ret_t    ret0, ret1, m_ret;

    logic rd_valid0, rd_rdy0, ret_valid0, wr_valid0, wr_rdy0;
    logic rd_valid1, rd_rdy1, ret_valid1, wr_valid1, wr_rdy1;
    logic m_rd_valid, m_rd_rdy, m_ret_valid, m_wr_valid, m_wr_rdy;

    cache cache0 (
        .clk_g(clk_g), .rst(rst),
        .req(req0), .req_valid(req_valid0),
        .addr_ok(addr_ok0), .data_ok(data_ok0), .rdata(rdata0),
        .rd_req(rd_req0), .rd_valid(rd_valid0), .rd_rdy(rd_rdy0),
        .ret(ret0), .ret_valid(ret_valid0),
        .wr_req(wr_req0), .wr_valid(wr_valid0), .wr_rdy(wr_rdy0)
    );

    cache cache1 (
        .clk_g(clk_g), .rst(rst),
        .req(req1), .req_valid(req_valid1),
        .addr_ok(addr_ok1), .data_ok(data_ok1), .rdata(rdata1),
        .rd_req(rd_req1), .rd_valid(rd_valid1), .rd_rdy(rd_rdy1),
        .ret(ret1), .ret_valid(ret_valid1),
        .wr_req(wr_req1), .wr_valid(wr_valid1), .wr_rdy(wr_rdy1)
    );

    mem_arbiter arbiter (
        .clk_g(clk_g), .rst(rst),
        .rd_req0(rd_req0), .rd_valid0(rd_valid0), .rd_rdy0(rd_rdy0),
        .ret0(ret0), .ret_valid0(ret_valid0),
        .wr_req0(wr_req0), .wr_valid0(wr_valid0), .wr_rdy0(wr_rdy0),
        .rd_req1(rd_req1), .rd_valid1(rd_valid1), .rd_rdy1(rd_rdy1),
        .ret1(ret1), .ret_valid1(ret_valid1),
        .wr_req1(wr_req1), .wr_valid1(wr_valid1), .wr_rdy1(wr_rdy1),
        .m_rd_req(m_rd_req), .m_rd_valid(m_rd_valid), .m_rd_rdy(m_rd_rdy),
        .m_ret(m_ret), .m_ret_valid(m_ret_valid),
        .m_wr_req(m_wr_req), .m_wr_valid(m_wr_valid), .m_wr_rdy(m_wr_rdy)
    );

    mem_model memory (
        .clk_g(clk_g), .rst(rst),
        .rd_req(m_rd_req), .rd_valid(m_rd_valid), .rd_rdy(m_rd_rdy),
        .ret(m_ret), .ret_valid(m_ret_valid),
        .wr_req(m_wr_req), .wr_valid(m_wr_valid), .wr_rdy(m_wr_rdy)
    );

endmodule

/* testbench/cache_top_tb.sv */
`timescale 1ns/1ps

module cache_top_tb;
    import cache_pkg::*;

    localparam int OPS_BASIC      = 28;
    localparam int OPS_EVICT      = 64;
    localparam int OPS_SHARED     = 64;
    localparam int RANDOM_ROUNDS  = 400;
    localparam int MISS_BOUND     = 40;
    localparam int TIMEOUT_CYCLES =
        (OPS_BASIC + OPS_EVICT + OPS_SHARED + 2 * RANDOM_ROUNDS) * MISS_BOUND + 300;
    // Partial strobes for words 0 to 3
    localparam logic [15:0] PART_STROBES = 16'ha681;

    logic        clk_g;
    logic        rst;
    cache_req_t  req0;
    cache_req_t  req1;
    logic        req_valid0;
    logic        req_valid1;
    logic        addr_ok0;
    logic        addr_ok1;
    logic        data_ok0;
    logic        data_ok1;
    logic [31:0] rdata0;
    logic [31:0] rdata1;

    logic [31:0] lfsr_state;
    logic [31:0] shadow [1 << 14];
    logic        written [1 << 14];
    // Bit 32 marks a load and the low bits hold its expected word
    logic [32:0] pend0 [$];
    logic [32:0] pend1 [$];
    string       test_name;
    int          err_count;
    int          pass_count;
    int          test_err_start;

    cache_top cache_top_inst (
        .clk_g(clk_g), .rst(rst),
        .req0(req0), .req_valid0(req_valid0),
        .addr_ok0(addr_ok0), .data_ok0(data_ok0), .rdata0(rdata0),
        .req1(req1), .req_valid1(req_valid1),
        .addr_ok1(addr_ok1), .data_ok1(data_ok1), .rdata1(rdata1)
    );

    initial begin
        clk_g = 1'b0;
        forever #2 clk_g = ~clk_g;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_g);
        $display("Run timed out after %0d cycles in test %s", TIMEOUT_CYCLES, test_name);
        $display("Done: errors found");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [13:0] word_of(input cache_req_t r);
        return {r.tag[3:0], r.index, r.offset[3:2]};
    endfunction

    // Last value stored at the word whatever the cache evicted meanwhile
    function automatic logic [31:0] expected_word(input logic [13:0] w);
        return shadow[w];
    endfunction

    task automatic store_to_shadow(input logic [13:0] w, input logic [3:0] strb,
                                   input logic [31:0] data);
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                shadow[w][8*i +: 8] = data[8*i +: 8];
            end
        end
        written[w] = 1'b1;
    endtask

    function automatic logic [31:0] pattern(input logic [19:0] tag, input logic [7:0] index,
                                            input int word);
        logic [13:0] w;
        w = {tag[3:0], index, 2'(word)};
        return {w, 2'b10, ~w, 2'b01};
    endfunction

    function automatic cache_req_t make_req(input cache_op_e op, input logic [19:0] tag,
                                            input logic [7:0] index, input int word,
                                            input logic [3:0] strb, input logic [31:0] data);
        cache_req_t r;
        r.op     = op;
        r.index  = index;
        r.tag    = tag;
        r.offset = 4'(word * 4);
        r.wstrb  = strb;
        r.wdata  = data;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            err_count++;
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
        end else begin
            pass_count++;
        end
    endtask

    task automatic retire_response(input int port, input logic [31:0] act);
        logic [32:0] entry;
        if ((port == 0 && pend0.size() == 0) || (port == 1 && pend1.size() == 0)) begin
            err_count++;
            $display("Port %0d raised data_ok with no request pending in test %s",
                     port, test_name);
        end else begin
            if (port == 0) begin
                entry = pend0.pop_front();
            end else begin
                entry = pend1.pop_front();
            end
            if (entry[32]) begin
                check_value($sformatf("%s port %0d load", test_name, port), entry[31:0], act);
            end
        end
    endtask

    always @(posedge clk_g) begin
        if (rst === 1'b0) begin
            if (data_ok0 === 1'b1) begin
                retire_response(0, rdata0);
            end
            if (data_ok1 === 1'b1) begin
                retire_response(1, rdata1);
            end
        end
    end

    // Issue one request and wait for acceptance and then for data_ok
    task automatic access(input int port, input cache_req_t r, output int lat);
        logic [13:0] w;
        logic        seen;
        w = word_of(r);
        if (port == 0) begin
            pend0.push_back({r.op == OP_LOAD, expected_word(w)});
            req0       <= r;
            req_valid0 <= 1'b1;
        end else begin
            pend1.push_back({r.op == OP_LOAD, expected_word(w)});
            req1       <= r;
            req_valid1 <= 1'b1;
        end
        if (r.op == OP_STORE) begin
            store_to_shadow(w, r.wstrb, r.wdata);
        end
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk_g);
            seen = (port == 0) ? addr_ok0 : addr_ok1;
        end
        if (port == 0) begin
            req_valid0 <= 1'b0;
        end else begin
            req_valid1 <= 1'b0;
        end
        lat  = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk_g);
            lat++;
            seen = (port == 0) ? data_ok0 : data_ok1;
        end
    endtask

    task automatic basic_port(input int p);
        logic [19:0] tag;
        int          lat;
        tag = 20'(p * 8);
        for (int k = 0; k < 4; k++) begin
            access(p, make_req(OP_STORE, tag, 8'h05, k, 4'hf, pattern(tag, 8'h05, k)), lat);
        end
        for (int k = 0; k < 4; k++) begin
            access(p, make_req(OP_STORE, tag, 8'h05, k, PART_STROBES[4*k +: 4],
                               ~pattern(tag, 8'h05, k)), lat);
        end
        for (int k = 0; k < 4; k++) begin
            access(p, make_req(OP_LOAD, tag, 8'h05, k, 4'h0, 32'h0), lat);
        end
        // Resident line answers one cycle after acceptance
        for (int k = 1; k < 3; k++) begin
            access(p, make_req(OP_LOAD, tag, 8'h05, k, 4'h0, 32'h0), lat);
            check_value($sformatf("%s port %0d hit latency", test_name, p), 32'd1, 32'(lat));
        end
    endtask

    task automatic evict_port(input int p);
        logic [19:0] tag;
        int          lat;
        for (int op = 0; op < 2; op++) begin
            for (int t = 0; t < 4; t++) begin
                tag = 20'(p * 8 + t);
                for (int k = 0; k < 4; k++) begin
                    if (op == 0) begin
                        access(p, make_req(OP_STORE, tag, 8'h3c, k, 4'hf,
                                           pattern(tag, 8'h3c, k)), lat);
                    end else begin
                        access(p, make_req(OP_LOAD, tag, 8'h3c, k, 4'h0, 32'h0), lat);
                    end
                end
            end
        end
    endtask

    // Four tags per index so most reloads come back through memory
    task automatic shared_port(input int p);
        logic [19:0] tag;
        logic [7:0]  index;
        int          lat;
        for (int op = 0; op < 2; op++) begin
            for (int k = 0; k < 16; k++) begin
                tag   = 20'(p * 8 + 4 + k / 4);
                index = 8'(8'h80 + k % 4);
                if (op == 0) begin
                    access(p, make_req(OP_STORE, tag, index, k % 4, 4'hf,
                                       pattern(tag, index, k % 4)), lat);
                end else begin
                    access(p, make_req(OP_LOAD, tag, index, k % 4, 4'h0, 32'h0), lat);
                end
            end
        end
    endtask

    task automatic draw_request(input int p, output cache_req_t r);
        logic [31:0] v;
        draw_bits(1, v);
        r.op = v[0] ? OP_STORE : OP_LOAD;
        draw_bits(3, v);
        r.tag = {16'd0, 1'(p), v[2:0]};
        draw_bits(4, v);
        r.index = {4'd0, v[3:0]};
        draw_bits(2, v);
        r.offset = {v[1:0], 2'b00};
        draw_bits(4, v);
        r.wstrb = v[3:0];
        draw_bits(32, v);
        r.wdata = v;
        // Never load an unwritten word and fill a new word completely
        if (!written[word_of(r)]) begin
            r.op    = OP_STORE;
            r.wstrb = 4'hf;
        end
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = err_count;
    endtask

    task automatic finish_test();
        $display("Test %s finished with %0d errors", test_name, err_count - test_err_start);
    endtask

    task automatic check_quiet_outputs();
        check_value("reset outputs", 32'd0,
                    {28'd0, addr_ok0, addr_ok1, data_ok0, data_ok1});
    endtask

    initial begin
        cache_req_t r0;
        cache_req_t r1;
        int         lat0;
        int         lat1;
        logic       ready;
        rst        <= 1'b1;
        req0       <= '0;
        req1       <= '0;
        req_valid0 <= 1'b0;
        req_valid1 <= 1'b0;
        lfsr_state = 32'd84473;
        err_count  = 0;
        pass_count = 0;
        for (int i = 0; i < (1 << 14); i++) begin
            written[i] = 1'b0;
        end

        start_test("reset");
        for (int i = 0; i < 16; i++) begin
            @(posedge clk_g);
            if (i > 0) begin
                check_quiet_outputs();
            end
        end
        rst <= 1'b0;
        repeat (256) begin
            @(posedge clk_g);
            check_quiet_outputs();
        end
        ready = 1'b0;
        for (int i = 0; i < 8 && !ready; i++) begin
            @(posedge clk_g);
            ready = (addr_ok0 === 1'b1) && (addr_ok1 === 1'b1);
        end
        if (!ready) begin
            err_count++;
            $display("addr_ok did not rise on both ports after the reset sweep");
        end
        finish_test();

        start_test("store_load_hits");
        fork
            basic_port(0);
            basic_port(1);
        join
        finish_test();

        start_test("eviction");
        fork
            evict_port(0);
            evict_port(1);
        join
        finish_test();

        start_test("shared_bus");
        fork
            shared_port(0);
            shared_port(1);
        join
        finish_test();

        start_test("random_traffic");
        for (int i = 0; i < RANDOM_ROUNDS; i++) begin
            draw_request(0, r0);
            draw_request(1, r1);
            fork
                access(0, r0, lat0);
                access(1, r1, lat1);
            join
        end
        finish_test();

        // Let the last responses retire
        @(posedge clk_g);
        $display("Checks passed: %0d, errors: %0d", pass_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* cache_top.f */
common/cache_pkg.sv
cache/cache_ram.sv
cache/cache.sv
design/mem_arbiter.sv
design/mem_model.sv
design/cache_top.sv
testbench/cache_top_tb.sv

/* Makefile */
TOP := cache_top_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -sv -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f cache_top.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "^Done: no errors$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
